// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // base opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  we,
    input  wire [reg_addr_w-1:0] rd_addr,
    input  wire [xlen-1:0]       rd_data,
    input  wire [reg_addr_w-1:0] rs1_addr,
    input  wire [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]      rs1_data,
    output logic [xlen-1:0]      rs2_data
);

    logic [xlen-1:0] regs [0:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk) begin
        if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads as zero, entry 0 is never written
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_wdata_known: assert property (@(posedge clk) disable iff (!rstn)
        we |-> !$isunknown(rd_data));

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             order,
    input  wire [xlen-1:0]  pc,
    input  wire [xlen-1:0]  imem_data,
    output logic            accepted,
    output logic            done,
    output logic [xlen-1:0] inst,
    output logic [xlen-1:0] imem_addr
);

    // 0 idle, 1 address out, 2 word back from memory
    logic [1:0] phase;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase    <= 2'd0;
            accepted <= 1'b0;
            done     <= 1'b0;
        end else begin
            accepted <= 1'b0;
            done     <= 1'b0;
            case (phase)
                2'd0: begin
                    if (order) begin
                        phase    <= 2'd1;
                        accepted <= 1'b1;
                    end
                end
                2'd1: phase <= 2'd2;
                default: begin
                    phase <= 2'd0;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == 2'd0 && order) begin
            imem_addr <= pc;
        end
        if (phase == 2'd2) begin
            inst <= imem_data;
        end
    end

    // the sequencer waits for done before it orders again
    a_order_idle: assert property (@(posedge clk) disable iff (!rstn)
        $rose(order) |-> phase == 2'd0);

endmodule

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  wire [xlen-1:0]        inst,
    output alu_op_t               alu_op,
    output logic                  use_imm,
    output logic                  is_alu,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  is_lui,
    output logic                  is_auipc,
    output logic                  illegal,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic [2:0]            funct3,
    output logic [xlen-1:0]       imm
);

    logic [6:0]      opcode;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode   = inst[6:0];
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign is_lui    = opcode == op_lui;
    assign is_auipc  = opcode == op_auipc;
    assign is_jal    = opcode == op_jal;
    assign is_jalr   = opcode == op_jalr;
    assign is_branch = opcode == op_branch;
    assign is_load   = opcode == op_load;
    assign is_store  = opcode == op_store;
    assign use_imm   = opcode == op_imm;
    assign is_alu    = use_imm || opcode == op_reg;
    assign illegal   = !(is_lui || is_auipc || is_jal || is_jalr || is_branch ||
                         is_load || is_store || is_alu);

    always_comb begin
        case (opcode)
            op_store:        imm = imm_s;
            op_branch:       imm = imm_b;
            op_lui, op_auipc: imm = imm_u;
            op_jal:          imm = imm_j;
            default:         imm = imm_i;
        endcase
    end

    // bit 30 picks sub only for register ops, addi has no such form
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == op_reg && inst[30]) ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             order,
    input  wire alu_op_t    op,
    input  wire [xlen-1:0]  a,
    input  wire [xlen-1:0]  b,
    output logic            accepted,
    output logic            done,
    output logic [xlen-1:0] result
);

    logic            busy;
    alu_op_t         op_q;
    logic [xlen-1:0] b_q;
    logic [4:0]      shamt;
    logic            is_shift;
    logic [xlen-1:0] calc;

    assign is_shift = op_q inside {alu_sll, alu_srl, alu_sra};

    // shifts step one bit per pass through calc
    always_comb begin
        case (op_q)
            alu_add:  calc = result + b_q;
            alu_sub:  calc = result - b_q;
            alu_and:  calc = result & b_q;
            alu_or:   calc = result | b_q;
            alu_xor:  calc = result ^ b_q;
            alu_slt:  calc = {{(xlen-1){1'b0}}, $signed(result) < $signed(b_q)};
            alu_sltu: calc = {{(xlen-1){1'b0}}, result < b_q};
            alu_sll:  calc = {result[xlen-2:0], 1'b0};
            alu_srl:  calc = {1'b0, result[xlen-1:1]};
            default:  calc = {result[xlen-1], result[xlen-1:1]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            accepted <= 1'b0;
            done     <= 1'b0;
        end else begin
            accepted <= 1'b0;
            done     <= 1'b0;
            if (!busy) begin
                if (order) begin
                    busy     <= 1'b1;
                    accepted <= 1'b1;
                end
            end else if (!is_shift || shamt == '0) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // result doubles as the a operand and the shift register
    always_ff @(posedge clk) begin
        if (!busy && order) begin
            op_q   <= op;
            result <= a;
            b_q    <= b;
            shamt  <= b[4:0];
        end else if (busy && (!is_shift || shamt != '0)) begin
            result <= calc;
            shamt  <= shamt - 5'd1;
        end
    end

    // order is down again by the time the result is out
    a_order_low: assert property (@(posedge clk) disable iff (!rstn)
        done |-> !order);

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import rv_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             order,
    input  wire             write,
    input  wire [2:0]       funct3,
    input  wire [xlen-1:0]  addr,
    input  wire [xlen-1:0]  wdata,
    input  wire [xlen-1:0]  dmem_rdata,
    input  wire             dmem_ready,
    output logic            accepted,
    output logic            done,
    output logic [xlen-1:0] rdata,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic [3:0]      dmem_we,
    output logic            dmem_re
);

    logic            busy;
    logic [2:0]      funct3_q;
    logic [1:0]      off_q;
    logic [7:0]      lane_byte;
    logic [xlen-1:0] loaded;

    // funct3[1] marks a word, funct3[2] an unsigned byte
    assign lane_byte = dmem_rdata[8*off_q +: 8];
    assign loaded    = funct3_q[1] ? dmem_rdata :
                       {{(xlen-8){lane_byte[7] & ~funct3_q[2]}}, lane_byte};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            accepted <= 1'b0;
            done     <= 1'b0;
            dmem_we  <= 4'b0;
            dmem_re  <= 1'b0;
        end else begin
            accepted <= 1'b0;
            done     <= 1'b0;
            if (!busy && order) begin
                busy     <= 1'b1;
                accepted <= 1'b1;
                dmem_re  <= !write;
                dmem_we  <= !write ? 4'b0000 :
                            funct3[1] ? 4'b1111 : 4'b0001 << addr[1:0];
            end else if (busy && dmem_ready) begin
                busy    <= 1'b0;
                done    <= 1'b1;
                dmem_we <= 4'b0;
                dmem_re <= 1'b0;
            end
        end
    end

    // byte stores go out on every lane, the enable picks one
    always_ff @(posedge clk) begin
        if (!busy && order) begin
            funct3_q   <= funct3;
            off_q      <= addr[1:0];
            dmem_addr  <= {addr[xlen-1:2], 2'b00};
            dmem_wdata <= funct3[1] ? wdata : {4{wdata[7:0]}};
        end
        if (busy && dmem_ready) begin
            rdata <= loaded;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rstn)
        (busy && funct3_q[1]) |-> off_q == 2'b00);

endmodule

`default_nettype wire

// File: src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rstn,
    output logic [xlen-1:0] imem_addr,
    input  wire [xlen-1:0]  imem_data,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic [3:0]      dmem_we,
    output logic            dmem_re,
    input  wire [xlen-1:0]  dmem_rdata,
    input  wire             dmem_ready,
    output logic            halted
);

    typedef enum logic [2:0] {
        st_fetch, st_fetch_wait, st_decode, st_execute,
        st_execute_wait, st_write, st_halt
    } state_t;

    state_t          state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] inst_q;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    alu_op_t         alu_op_q;
    logic            wr_en;
    logic [xlen-1:0] wr_data;
    logic            fetch_order;
    logic            alu_order;
    logic            lsu_order;

    logic                  fetch_accepted;
    logic                  fetch_done;
    logic [xlen-1:0]       fetch_inst;
    alu_op_t               dec_alu_op;
    logic                  use_imm;
    logic                  is_alu;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  illegal;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic [2:0]            funct3;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  alu_accepted;
    logic                  alu_done;
    logic [xlen-1:0]       alu_result;
    logic                  lsu_accepted;
    logic                  lsu_done;
    logic [xlen-1:0]       lsu_rdata;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_rel;
    logic [xlen-1:0] base_sum;
    logic            cmp;
    logic            taken;

    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + imm;
    // load/store address and jalr target share one adder
    assign base_sum = op_a + imm;
    assign halted   = state == st_halt;

    // funct3[0] inverts eq and lt into ne and ge
    always_comb begin
        case (funct3[2:1])
            2'b00:   cmp = op_a == op_b;
            2'b10:   cmp = $signed(op_a) < $signed(op_b);
            default: cmp = op_a < op_b;
        endcase
        taken = cmp ^ funct3[0];
    end

    reg_file u_reg_file (
        .clk(clk), .rstn(rstn), .we(state == st_write && wr_en),
        .rd_addr(rd_addr), .rd_data(wr_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    fetch_unit u_fetch (
        .clk(clk), .rstn(rstn), .order(fetch_order), .pc(pc), .imem_data(imem_data),
        .accepted(fetch_accepted), .done(fetch_done), .inst(fetch_inst),
        .imem_addr(imem_addr)
    );

    decoder u_decoder (
        .inst(inst_q), .alu_op(dec_alu_op), .use_imm(use_imm), .is_alu(is_alu),
        .is_load(is_load), .is_store(is_store), .is_branch(is_branch),
        .is_jal(is_jal), .is_jalr(is_jalr), .is_lui(is_lui), .is_auipc(is_auipc),
        .illegal(illegal), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rd_addr(rd_addr), .funct3(funct3), .imm(imm)
    );

    alu u_alu (
        .clk(clk), .rstn(rstn), .order(alu_order), .op(alu_op_q),
        .a(op_a), .b(use_imm ? imm : op_b),
        .accepted(alu_accepted), .done(alu_done), .result(alu_result)
    );

    load_store_unit u_lsu (
        .clk(clk), .rstn(rstn), .order(lsu_order), .write(is_store), .funct3(funct3),
        .addr(base_sum), .wdata(op_b), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready),
        .accepted(lsu_accepted), .done(lsu_done), .rdata(lsu_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(dmem_re)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= st_fetch;
            pc          <= RESET_PC;
            wr_en       <= 1'b0;
            fetch_order <= 1'b0;
            alu_order   <= 1'b0;
            lsu_order   <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    fetch_order <= 1'b1;
                    state       <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (fetch_accepted) begin
                        fetch_order <= 1'b0;
                    end
                    if (fetch_done) begin
                        inst_q <= fetch_inst;
                        state  <= st_decode;
                    end
                end
                st_decode: begin
                    op_a     <= rs1_data;
                    op_b     <= rs2_data;
                    alu_op_q <= dec_alu_op;
                    state    <= illegal ? st_halt : st_execute;
                end
                st_execute: begin
                    next_pc <= pc_plus4;
                    wr_en   <= 1'b1;
                    state   <= st_write;
                    if (is_branch) begin
                        wr_en <= 1'b0;
                        if (taken) begin
                            next_pc <= pc_rel;
                        end
                    end else if (is_jal) begin
                        next_pc <= pc_rel;
                        wr_data <= pc_plus4;
                    end else if (is_jalr) begin
                        next_pc <= {base_sum[xlen-1:1], 1'b0};
                        wr_data <= pc_plus4;
                    end else if (is_lui) begin
                        wr_data <= imm;
                    end else if (is_auipc) begin
                        wr_data <= pc_rel;
                    end else if (is_alu) begin
                        alu_order <= 1'b1;
                        state     <= st_execute_wait;
                    end else begin
                        lsu_order <= 1'b1;
                        state     <= st_execute_wait;
                    end
                end
                st_execute_wait: begin
                    if (alu_accepted) begin
                        alu_order <= 1'b0;
                    end
                    if (lsu_accepted) begin
                        lsu_order <= 1'b0;
                    end
                    if (alu_done) begin
                        wr_data <= alu_result;
                        state   <= st_write;
                    end
                    if (lsu_done) begin
                        wr_data <= lsu_rdata;
                        wr_en   <= is_load;
                        state   <= st_write;
                    end
                end
                st_write: begin
                    pc    <= next_pc;
                    state <= st_fetch;
                end
                // halt holds until reset
                default: state <= st_halt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH
`default_nettype none

localparam int n_tests   = 6;
localparam int max_words = 12;

string       prog_name     [n_tests];
int          prog_len      [n_tests];
logic [31:0] prog_words    [n_tests][max_words];
logic [31:0] prog_addr     [n_tests];
logic [31:0] prog_expected [n_tests];
bit          prog_stall    [n_tests];
bit          prog_halt     [n_tests];

// RV32I encoders taking their fields as plain ints
function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                      input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] itype(input int op, input int f3, input int rd,
                                      input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

// stores rs2 to imm(rs1)
function automatic logic [31:0] stype(input int f3, input int rs1, input int rs2,
                                      input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                      input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
endfunction

function automatic logic [31:0] utype(input int op, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] jtype(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// sb, lb, lbu and lw around base 0x80, then store the sum
task automatic set_memory_program(input int t);
    prog_words[t][0] = itype('h13, 0, 1, 0, 'h80);
    prog_words[t][1] = itype('h13, 0, 2, 0, 'ha5);
    prog_words[t][2] = stype(2, 1, 0, 0);
    prog_words[t][3] = stype(0, 1, 2, 2);
    prog_words[t][4] = itype('h03, 0, 3, 1, 2);
    prog_words[t][5] = itype('h03, 4, 4, 1, 2);
    prog_words[t][6] = itype('h03, 2, 5, 1, 0);
    prog_words[t][7] = rtype(0, 0, 6, 3, 4);
    prog_words[t][8] = rtype(0, 0, 6, 6, 5);
    prog_words[t][9] = stype(2, 0, 6, 'h100);
    prog_len[t]      = 10;
    prog_addr[t]     = 32'h100;
    // ffffffa5 + a5 + 00a50000
    prog_expected[t] = 32'h00a5004a;
endtask

task automatic fill_program_table();
    for (int t = 0; t < n_tests; t++) begin
        prog_stall[t] = 1'b0;
        prog_halt[t]  = 1'b0;
        prog_addr[t]  = 32'h100;
    end

    prog_name[0]      = "alu_ops";
    prog_words[0][0]  = utype('h37, 1, 'h12345);
    prog_words[0][1]  = itype('h13, 0, 1, 1, 'h678);
    prog_words[0][2]  = itype('h13, 0, 2, 0, -3);
    prog_words[0][3]  = rtype(7'h20, 0, 3, 1, 2);
    prog_words[0][4]  = rtype(0, 7, 4, 3, 2);
    prog_words[0][5]  = rtype(0, 4, 4, 4, 1);
    prog_words[0][6]  = rtype(0, 2, 5, 2, 1);
    prog_words[0][7]  = rtype(0, 3, 6, 1, 2);
    prog_words[0][8]  = rtype(0, 0, 7, 5, 6);
    prog_words[0][9]  = rtype(0, 6, 8, 7, 1);
    prog_words[0][10] = rtype(0, 0, 8, 8, 4);
    prog_words[0][11] = stype(2, 0, 8, 'h100);
    prog_len[0]       = 12;
    prog_expected[0]  = 32'h1234567b;

    // shifts by 0, 1, 17 and 31 on the operand fffff8f0
    prog_name[1]      = "shifts";
    prog_words[1][0]  = itype('h13, 0, 1, 0, 'h8f0);
    prog_words[1][1]  = rtype(0, 1, 2, 1, 0);
    prog_words[1][2]  = itype('h13, 5, 3, 1, 17);
    prog_words[1][3]  = itype('h13, 5, 4, 1, 'h401);
    prog_words[1][4]  = itype('h13, 0, 5, 0, 31);
    prog_words[1][5]  = rtype('h20, 5, 7, 1, 5);
    prog_words[1][6]  = rtype(0, 1, 8, 7, 5);
    prog_words[1][7]  = itype('h13, 5, 6, 8, 1);
    prog_words[1][8]  = rtype(0, 4, 9, 2, 3);
    prog_words[1][9]  = rtype(0, 0, 9, 9, 4);
    prog_words[1][10] = rtype(0, 4, 9, 9, 6);
    prog_words[1][11] = stype(2, 0, 9, 'h100);
    prog_len[1]       = 12;
    prog_expected[1]  = 32'hbfff8387;

    prog_name[2] = "byte_word_mem";
    set_memory_program(2);

    // countdown 5..1 into x2, then blt/bge both ways against x1 = 0
    prog_name[3]      = "branches";
    prog_words[3][0]  = itype('h13, 0, 1, 0, 5);
    prog_words[3][1]  = itype('h13, 0, 2, 0, 0);
    prog_words[3][2]  = rtype(0, 0, 2, 2, 1);
    prog_words[3][3]  = itype('h13, 0, 1, 1, -1);
    prog_words[3][4]  = btype(1, 1, 0, -8);
    prog_words[3][5]  = btype(4, 1, 2, 8);
    prog_words[3][6]  = itype('h13, 0, 2, 2, 'h100);
    prog_words[3][7]  = btype(4, 2, 1, 8);
    prog_words[3][8]  = btype(5, 2, 1, 8);
    prog_words[3][9]  = itype('h13, 0, 2, 2, 'h200);
    prog_words[3][10] = btype(5, 1, 2, 8);
    prog_words[3][11] = stype(2, 0, 2, 'h100);
    prog_len[3]       = 12;
    prog_expected[3]  = 32'd15;

    // jal links at index 1 and jalr at index 9
    prog_name[4]     = "jumps";
    prog_words[4][0] = itype('h13, 0, 5, 0, 'h10);
    prog_words[4][1] = jtype(1, 20);
    prog_words[4][2] = rtype(0, 0, 5, 5, 1);
    prog_words[4][3] = rtype(0, 0, 5, 5, 6);
    prog_words[4][4] = stype(2, 0, 5, 'h100);
    prog_words[4][5] = jtype(0, 0);
    prog_words[4][6] = itype('h13, 0, 5, 5, 3);
    prog_words[4][7] = jtype(0, 8);
    prog_words[4][8] = itype('h13, 0, 5, 5, 'h100);
    prog_words[4][9] = itype('h67, 0, 6, 1, 0);
    prog_len[4]      = 10;
    prog_expected[4] = 32'd19 + (reset_pc + 32'd8) + (reset_pc + 32'd40);

    prog_name[5] = "stall_and_halt";
    set_memory_program(5);
    prog_words[5][10] = 32'h0000_0000;
    prog_len[5]       = 11;
    prog_stall[5]     = 1'b1;
    prog_halt[5]      = 1'b1;
endtask

`default_nettype wire
`endif

// File: testbench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam logic [31:0] reset_pc  = 32'h80;
    localparam logic [31:0] spin_word = 32'h0000006f;

    logic        clk;
    logic        rstn;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;
    logic        dmem_ready;
    logic        halted;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] fetch_addr;
    logic [31:0] check_addr;
    logic [31:0] store_val;
    bit          stall_en;
    bit          req_open;
    bit          store_seen;
    int          stall_left;
    int          we_count;
    int          passes;
    int          fails;

    `include "tb_programs.svh"

    cpu_core #(.RESET_PC(reset_pc)) dut (
        .clk(clk), .rstn(rstn), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction rom answers one cycle after it takes the address
    always @(posedge clk) begin
        #1;
        imem_data  = rom[fetch_addr[9:2]];
        fetch_addr = imem_addr;
    end

    // data ram with optional random ready stalls
    always @(posedge clk) begin
        #1 dmem_ready = 1'b0;
        if (dmem_re || dmem_we != 4'b0) begin
            if (!req_open) begin
                req_open   = 1'b1;
                stall_left = stall_en ? int'($urandom % 4) : 0;
            end
            if (stall_left > 0) begin
                stall_left--;
            end else begin
                dmem_rdata = ram[dmem_addr[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_we[b]) begin
                        ram[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                    end
                end
                if (dmem_we != 4'b0) begin
                    we_count++;
                    if (dmem_addr == check_addr && !store_seen) begin
                        store_seen = 1'b1;
                        store_val  = ram[dmem_addr[9:2]];
                    end
                end
                dmem_ready = 1'b1;
                req_open   = 1'b0;
            end
        end
    end

    task automatic load_memories(input int t);
        for (int i = 0; i < 256; i++) begin
            rom[i] = spin_word;
            ram[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0]};
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            rom[int'(reset_pc[9:2]) + i] = prog_words[t][i];
        end
    endtask

    task automatic run_program(input int t);
        int cyc;
        int we_snap;
        bit failed;
        failed = 1'b0;
        @(posedge clk);
        #1 rstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        load_memories(t);
        stall_en   = prog_stall[t];
        check_addr = prog_addr[t];
        store_seen = 1'b0;
        req_open   = 1'b0;
        we_count   = 0;
        rstn       = 1'b1;

        cyc = 0;
        while (!store_seen && !halted && cyc < 2000) begin
            @(negedge clk);
            cyc++;
        end
        if (!store_seen) begin
            failed = 1'b1;
            if (halted) begin
                $display("test %s: core halted before the check store", prog_name[t]);
            end else begin
                $display("test %s: timed out waiting for the check store", prog_name[t]);
            end
        end else if (store_val !== prog_expected[t]) begin
            failed = 1'b1;
            $display("error at %0t: store_val = %h, expected %h (%s)",
                     $time, store_val, prog_expected[t], prog_name[t]);
        end

        if (!failed && prog_halt[t]) begin
            cyc = 0;
            while (!halted && cyc < 200) begin
                @(negedge clk);
                cyc++;
            end
            if (!halted) begin
                failed = 1'b1;
                $display("test %s: halted did not rise after the illegal word", prog_name[t]);
            end else begin
                we_snap = we_count;
                repeat (50) @(negedge clk);
                if (we_count != we_snap || !halted) begin
                    failed = 1'b1;
                    $display("test %s: memory was written or halted dropped after halt",
                             prog_name[t]);
                end
            end
        end

        if (failed) begin
            fails++;
            $display("test %0d %s: FAIL", t, prog_name[t]);
        end else begin
            passes++;
            $display("test %0d %s: ok", t, prog_name[t]);
        end
    endtask

    initial begin
        void'($urandom(61946));
        rstn       = 1'b0;
        imem_data  = '0;
        dmem_rdata = '0;
        dmem_ready = 1'b0;
        fetch_addr = '0;
        stall_en   = 1'b0;
        req_open   = 1'b0;
        store_seen = 1'b0;
        check_addr = 32'h100;
        we_count   = 0;
        passes     = 0;
        fails      = 0;
        fill_program_table();
        for (int t = 0; t < n_tests; t++) begin
            run_program(t);
        end
        $display("%0d passed, %0d failed, %0d tests", passes, fails, n_tests);
        if (fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
src/rv_pkg.sv
src/reg_file.sv
src/fetch_unit.sv
src/decoder.sv
src/alu.sv
src/load_store_unit.sv
src/cpu_core.sv
testbench/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs tb_cpu with Verilator, passes only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f vlog.f \
    --Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_cpu > sim.log 2>&1

grep -q "All tests passed!" sim.log 2>/dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
